/* rtab_params.svh */
// Size macros for the replay table and its address fields
`ifndef RTAB_PARAMS_SVH
`define RTAB_PARAMS_SVH

// Number of parked requests the table can hold
`define RTAB_ENTRIES 4

// Cache-line index width
`define RTAB_NLINE_WIDTH 8

// Offset within a cache line
`define RTAB_OFFSET_WIDTH 4

// Request identifier returned with a replay
`define RTAB_TAG_WIDTH 6

// Low line-index bits that select a miss-table set
`define RTAB_MSHR_SET_WIDTH 2

`endif

/* rtl/rtab_pkg.sv */
// Vector, struct and enum types shared by the replay table blocks
package rtab_pkg;

`include "rtab_params.svh"

    typedef logic [`RTAB_NLINE_WIDTH-1:0]  rtab_nline_t;
    typedef logic [`RTAB_OFFSET_WIDTH-1:0] rtab_offset_t;
    typedef logic [`RTAB_TAG_WIDTH-1:0]    rtab_tag_t;

    // Entry index and one-bit-per-entry vector
    typedef logic [$clog2(`RTAB_ENTRIES)-1:0] rtab_ptr_t;
    typedef logic [`RTAB_ENTRIES-1:0]         rtab_bv_t;

    // Parked request
    typedef struct packed {
        rtab_nline_t  nline;
        rtab_offset_t offset;
        rtab_tag_t    tag;
    } rtab_req_t;

    // A set bit means the request waits for that condition
    typedef struct packed {
        logic mshr_hit;
        logic mshr_full;
        logic mshr_ready;
    } rtab_deps_t;

    // Pop FSM, walking a list from its head to its tail
    typedef enum logic [1:0] {
        POP_HEAD,
        POP_NEXT,
        POP_NEXT_WAIT
    } rtab_pop_state_e;

endpackage

/* rtl/rtab_rr_arbiter.sv */
// Round-robin one-hot arbiter with a grant that holds under back-pressure
`timescale 1ns/10ps

module rtab_rr_arbiter import rtab_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  rtab_bv_t req_i,
    input  logic     ready_i,
    output rtab_bv_t gnt_o
);
    // Requests at or above the mask have priority
    rtab_bv_t mask_q;
    rtab_bv_t gnt_q;
    logic     hold_q;
    rtab_bv_t masked_req;
    rtab_bv_t pick_masked;
    rtab_bv_t pick_any;
    rtab_bv_t next_mask;

    assign masked_req  = req_i & mask_q;
    // Isolate the lowest set bit
    assign pick_masked = masked_req & (~masked_req + rtab_bv_t'(1));
    assign pick_any    = req_i & (~req_i + rtab_bv_t'(1));

    // A grant that was offered but not taken stays put while still requested
    assign gnt_o = (hold_q && (gnt_q & req_i) != '0) ? gnt_q :
                   (masked_req != '0)                ? pick_masked : pick_any;

    // Bits strictly above the granted one
    assign next_mask = ~(gnt_o | (gnt_o - rtab_bv_t'(1)));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mask_q <= '0;
            gnt_q  <= '0;
            hold_q <= 1'b0;
        end else begin
            if (ready_i && gnt_o != '0) begin
                mask_q <= next_mask;
            end
            gnt_q  <= gnt_o;
            hold_q <= (gnt_o != '0) && !ready_i;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(gnt_o) && ((gnt_o & ~req_i) == '0))
        else $error("rtab_rr_arbiter: grant not one-hot or not requested");

endmodule

/* rtl/rtab_deps_tracker.sv */
// Per-entry miss-handler dependency flags with their set and clear rules
`timescale 1ns/10ps
`include "rtab_params.svh"

module rtab_deps_tracker import rtab_pkg::*; (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  rtab_bv_t                       alloc_bv_i,
    input  rtab_deps_t                     alloc_deps_i,
    input  rtab_bv_t                       rback_bv_i,
    input  rtab_deps_t                     rback_deps_i,
    input  rtab_nline_t [`RTAB_ENTRIES-1:0] nline_i,
    input  logic                           miss_ready_i,
    input  logic                           refill_i,
    input  rtab_nline_t                    refill_nline_i,
    output rtab_bv_t                       nodeps_o
);
    localparam int N     = `RTAB_ENTRIES;
    localparam int SET_W = `RTAB_MSHR_SET_WIDTH;

    rtab_bv_t hit_q, full_q, rdy_q;
    rtab_bv_t hit_set, full_set, rdy_set;
    rtab_bv_t hit_rst, full_rst, rdy_rst;
    rtab_bv_t load_bv;
    rtab_bv_t line_eq;
    rtab_bv_t set_eq;

    // Refill compares against every parked line
    always_comb begin
        for (int i = 0; i < N; i++) begin
            line_eq[i] = (nline_i[i] == refill_nline_i);
            set_eq[i]  = (nline_i[i][SET_W-1:0] == refill_nline_i[SET_W-1:0]);
        end
    end

    // A new or rolled-back entry loads its flags afresh
    assign load_bv = alloc_bv_i | rback_bv_i;

    assign hit_set  = (alloc_bv_i & {N{alloc_deps_i.mshr_hit}}) |
                      (rback_bv_i & {N{rback_deps_i.mshr_hit}});
    assign full_set = (alloc_bv_i & {N{alloc_deps_i.mshr_full}}) |
                      (rback_bv_i & {N{rback_deps_i.mshr_full}});
    assign rdy_set  = (alloc_bv_i & {N{alloc_deps_i.mshr_ready}}) |
                      (rback_bv_i & {N{rback_deps_i.mshr_ready}});

    assign hit_rst  = {N{refill_i}} & line_eq;
    assign full_rst = {N{refill_i}} & set_eq;
    assign rdy_rst  = {N{miss_ready_i}};

    // Set wins over a clear in the same cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            hit_q  <= '0;
            full_q <= '0;
            rdy_q  <= '0;
        end else begin
            hit_q  <= (hit_q  & ~hit_rst  & ~load_bv) | hit_set;
            full_q <= (full_q & ~full_rst & ~load_bv) | full_set;
            rdy_q  <= (rdy_q  & ~rdy_rst  & ~load_bv) | rdy_set;
        end
    end

    assign nodeps_o = ~(hit_q | full_q | rdy_q);

endmodule

/* rtl/rtab_entry_store.sv */
// Entry array and list flags with line match, free-slot choice and pop mux
`timescale 1ns/10ps
`include "rtab_params.svh"

module rtab_entry_store import rtab_pkg::*; (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  rtab_nline_t                     check_nline_i,
    output logic                            check_hit_o,
    input  logic                            alloc_i,
    input  logic                            alloc_link_i,
    input  rtab_req_t                       alloc_req_i,
    output rtab_bv_t                        alloc_bv_o,
    output rtab_nline_t [`RTAB_ENTRIES-1:0] nline_o,
    input  rtab_bv_t                        pop_sel_i,
    input  logic                            pop_take_i,
    input  logic                            commit_i,
    input  rtab_ptr_t                       commit_ptr_i,
    input  logic                            rback_i,
    input  rtab_ptr_t                       rback_ptr_i,
    output rtab_bv_t                        valid_o,
    output rtab_bv_t                        head_o,
    output rtab_bv_t                        tail_o,
    output rtab_bv_t                        sel_next_o,
    output rtab_req_t                       pop_req_o,
    output rtab_ptr_t                       pop_ptr_o,
    output logic                            empty_o,
    output logic                            full_o,
    input  logic                            cfg_single_entry_i
);
    localparam int N = `RTAB_ENTRIES;

    function automatic rtab_ptr_t bv_to_ptr(input rtab_bv_t bv);
        rtab_ptr_t ptr;
        ptr = '0;
        for (int i = 0; i < N; i++) begin
            if (bv[i]) begin
                ptr = rtab_ptr_t'(i);
            end
        end
        return ptr;
    endfunction

    rtab_req_t [N-1:0] req_q;
    rtab_ptr_t [N-1:0] next_q;
    rtab_bv_t          valid_q, head_q, tail_q;
    rtab_bv_t          free_vec, free_first;
    rtab_bv_t          match_line, match_tail;
    rtab_bv_t          take_bv, commit_bv, rback_bv;
    logic              alloc;

    assign alloc      = alloc_i | alloc_link_i;
    assign free_vec   = ~valid_q;
    // Lowest free index
    assign free_first = free_vec & (~free_vec + rtab_bv_t'(1));
    assign alloc_bv_o = free_first & {N{alloc}};

    always_comb begin
        for (int i = 0; i < N; i++) begin
            nline_o[i]    = req_q[i].nline;
            match_line[i] = valid_q[i] && (req_q[i].nline == check_nline_i);
        end
    end

    assign check_hit_o = |match_line;
    assign match_tail  = match_line & tail_q;

    assign take_bv   = pop_sel_i & {N{pop_take_i}};
    assign commit_bv = {N{commit_i}} & (rtab_bv_t'(1) << commit_ptr_i);
    assign rback_bv  = {N{rback_i}} & (rtab_bv_t'(1) << rback_ptr_i);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            head_q  <= '0;
            tail_q  <= '0;
        end else begin
            valid_q <= (valid_q | alloc_bv_o) & ~commit_bv;
            // Taken heads stay hidden until a rollback
            head_q  <= (head_q & ~take_bv & ~alloc_bv_o) |
                       (alloc_bv_o & {N{alloc_i}}) | rback_bv;
            // A link moves the tail flag onto the new entry
            tail_q  <= (tail_q & ~(match_tail & {N{alloc_link_i}}) & ~alloc_bv_o) |
                       alloc_bv_o;
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < N; i++) begin
            if (alloc_bv_o[i]) begin
                req_q[i] <= alloc_req_i;
            end
            if (alloc_link_i && match_tail[i]) begin
                next_q[i] <= bv_to_ptr(free_first);
            end
        end
    end

    // One-hot pop mux
    always_comb begin
        pop_req_o = '0;
        for (int i = 0; i < N; i++) begin
            if (pop_sel_i[i]) begin
                pop_req_o = req_q[i];
            end
        end
    end

    assign pop_ptr_o  = bv_to_ptr(pop_sel_i);
    assign sel_next_o = rtab_bv_t'(1) << next_q[pop_ptr_o];

    assign valid_o = valid_q;
    assign head_o  = head_q;
    assign tail_o  = tail_q;
    assign empty_o = (valid_q == '0);
    assign full_o  = (&valid_q) || ((valid_q != '0) && cfg_single_entry_i);

    assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(match_tail))
        else $error("rtab_entry_store: several tails on one line");
    assert property (@(posedge clk_i) disable iff (!rst_ni) alloc_link_i |-> check_hit_o)
        else $error("rtab_entry_store: link without a matching line");
    assert property (@(posedge clk_i) disable iff (!rst_ni) alloc |-> !full_o)
        else $error("rtab_entry_store: allocation while full");
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (commit_i |-> valid_q[commit_ptr_i]) and (rback_i |-> valid_q[rback_ptr_i]))
        else $error("rtab_entry_store: commit or rollback of an invalid entry");

endmodule

/* rtl/rtab_pop_ctrl.sv */
// Pop-try FSM that picks a ready head and walks its list to the tail
`timescale 1ns/10ps

module rtab_pop_ctrl import rtab_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  rtab_bv_t ready_i,
    input  rtab_bv_t tail_i,
    input  rtab_bv_t sel_next_i,
    input  logic     rback_i,
    input  logic     pop_try_i,
    output logic     pop_try_valid_o,
    output rtab_bv_t pop_sel_o
);
    rtab_pop_state_e state_q, state_d;
    rtab_bv_t        next_q, next_d;
    rtab_bv_t        gnt;
    logic            arb_adv;
    logic            sel_is_tail;

    rtab_rr_arbiter u_arbiter (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .req_i   (ready_i),
        .ready_i (arb_adv),
        .gnt_o   (gnt)
    );

    // Offer comes straight from the state
    always_comb begin
        if (state_q == POP_HEAD) begin
            pop_sel_o       = gnt;
            pop_try_valid_o = (gnt != '0);
        end else begin
            pop_sel_o       = next_q;
            pop_try_valid_o = 1'b1;
        end
    end

    assign sel_is_tail = (pop_sel_o & tail_i) != '0;

    always_comb begin
        state_d = state_q;
        next_d  = next_q;
        arb_adv = 1'b0;

        case (state_q)
            POP_HEAD: begin
                if (pop_try_i && pop_try_valid_o) begin
                    arb_adv = 1'b1;
                    // Follow the list unless the head was also its tail
                    if (!sel_is_tail) begin
                        state_d = POP_NEXT;
                        next_d  = sel_next_i;
                    end
                end
            end
            POP_NEXT: begin
                if (rback_i) begin
                    // Rolled-back entry heads the rest of the list again
                    state_d = POP_HEAD;
                end else if (pop_try_i) begin
                    if (sel_is_tail) begin
                        state_d = POP_HEAD;
                    end else begin
                        next_d = sel_next_i;
                    end
                end else begin
                    state_d = POP_NEXT_WAIT;
                end
            end
            POP_NEXT_WAIT: begin
                if (pop_try_i) begin
                    if (sel_is_tail) begin
                        state_d = POP_HEAD;
                    end else begin
                        state_d = POP_NEXT;
                        next_d  = sel_next_i;
                    end
                end
            end
            default: begin
                state_d = POP_HEAD;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= POP_HEAD;
            next_q  <= '0;
        end else begin
            state_q <= state_d;
            next_q  <= next_d;
        end
    end

    // The cache takes nothing while it rolls a request back
    assert property (@(posedge clk_i) disable iff (!rst_ni) rback_i |-> !pop_try_i)
        else $error("rtab_pop_ctrl: pop-try during rollback");

endmodule

/* rtl/rtab_top.sv */
// Replay table top level joining the entry store, dependency tracker and pop FSM
`timescale 1ns/10ps
`include "rtab_params.svh"

module rtab_top import rtab_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        check_i,
    input  rtab_nline_t check_nline_i,
    output logic        check_hit_o,
    input  logic        alloc_i,
    input  logic        alloc_link_i,
    input  rtab_req_t   alloc_req_i,
    input  rtab_deps_t  alloc_deps_i,
    output logic        pop_try_valid_o,
    input  logic        pop_try_i,
    output rtab_req_t   pop_try_req_o,
    output rtab_ptr_t   pop_try_ptr_o,
    input  logic        pop_commit_i,
    input  rtab_ptr_t   pop_commit_ptr_i,
    input  logic        pop_rback_i,
    input  rtab_ptr_t   pop_rback_ptr_i,
    input  rtab_deps_t  pop_rback_deps_i,
    input  logic        miss_ready_i,
    input  logic        refill_i,
    input  rtab_nline_t refill_nline_i,
    input  logic        cfg_single_entry_i,
    output logic        empty_o,
    output logic        full_o
);
    localparam int N = `RTAB_ENTRIES;

    rtab_bv_t          valid, head, tail, sel_next, nodeps, ready;
    rtab_bv_t          alloc_bv, rback_bv, pop_sel;
    rtab_nline_t [N-1:0] nline;
    logic              store_hit;
    logic              pop_take;

    assign check_hit_o = check_i & store_hit;
    assign pop_take    = pop_try_i & pop_try_valid_o;
    assign ready       = valid & head & nodeps;
    assign rback_bv    = {N{pop_rback_i}} & (rtab_bv_t'(1) << pop_rback_ptr_i);

    rtab_entry_store u_store (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .check_nline_i      (check_nline_i),
        .check_hit_o        (store_hit),
        .alloc_i            (alloc_i),
        .alloc_link_i       (alloc_link_i),
        .alloc_req_i        (alloc_req_i),
        .alloc_bv_o         (alloc_bv),
        .nline_o            (nline),
        .pop_sel_i          (pop_sel),
        .pop_take_i         (pop_take),
        .commit_i           (pop_commit_i),
        .commit_ptr_i       (pop_commit_ptr_i),
        .rback_i            (pop_rback_i),
        .rback_ptr_i        (pop_rback_ptr_i),
        .valid_o            (valid),
        .head_o             (head),
        .tail_o             (tail),
        .sel_next_o         (sel_next),
        .pop_req_o          (pop_try_req_o),
        .pop_ptr_o          (pop_try_ptr_o),
        .empty_o            (empty_o),
        .full_o             (full_o),
        .cfg_single_entry_i (cfg_single_entry_i)
    );

    rtab_deps_tracker u_deps (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .alloc_bv_i     (alloc_bv),
        .alloc_deps_i   (alloc_deps_i),
        .rback_bv_i     (rback_bv),
        .rback_deps_i   (pop_rback_deps_i),
        .nline_i        (nline),
        .miss_ready_i   (miss_ready_i),
        .refill_i       (refill_i),
        .refill_nline_i (refill_nline_i),
        .nodeps_o       (nodeps)
    );

    rtab_pop_ctrl u_pop (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .ready_i         (ready),
        .tail_i          (tail),
        .sel_next_i      (sel_next),
        .rback_i         (pop_rback_i),
        .pop_try_i       (pop_try_i),
        .pop_try_valid_o (pop_try_valid_o),
        .pop_sel_o       (pop_sel)
    );

    // Linking needs a live check on the same line and is not used in single-entry mode
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        alloc_link_i |-> (check_i && check_nline_i == alloc_req_i.nline && !cfg_single_entry_i))
        else $error("rtab_top: link without a matching check");

endmodule

/* tb/rtab_tb.sv */
// Directed testbench for the replay table with a queue model of parked requests
`timescale 1ns/10ps
`include "rtab_params.svh"

module rtab_tb import rtab_pkg::*; ();
    localparam int N = `RTAB_ENTRIES;
    // All six tests need well under 200 cycles, so this leaves a wide margin
    localparam int TIMEOUT_CYCLES = 2000;

    // Model entry: the request and the slot it must occupy
    typedef struct packed {
        rtab_req_t req;
        rtab_ptr_t ptr;
    } parked_t;

    logic        clk_i;
    logic        rst_ni;
    logic        check_i;
    rtab_nline_t check_nline_i;
    logic        check_hit_o;
    logic        alloc_i;
    logic        alloc_link_i;
    rtab_req_t   alloc_req_i;
    rtab_deps_t  alloc_deps_i;
    logic        pop_try_valid_o;
    logic        pop_try_i;
    rtab_req_t   pop_try_req_o;
    rtab_ptr_t   pop_try_ptr_o;
    logic        pop_commit_i;
    rtab_ptr_t   pop_commit_ptr_i;
    logic        pop_rback_i;
    rtab_ptr_t   pop_rback_ptr_i;
    rtab_deps_t  pop_rback_deps_i;
    logic        miss_ready_i;
    logic        refill_i;
    rtab_nline_t refill_nline_i;
    logic        cfg_single_entry_i;
    logic        empty_o;
    logic        full_o;

    parked_t     model_q[$];
    rtab_bv_t    used_m;
    integer      seed;
    int          cycle_cnt = 0;

    rtab_top UUT (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .check_i            (check_i),
        .check_nline_i      (check_nline_i),
        .check_hit_o        (check_hit_o),
        .alloc_i            (alloc_i),
        .alloc_link_i       (alloc_link_i),
        .alloc_req_i        (alloc_req_i),
        .alloc_deps_i       (alloc_deps_i),
        .pop_try_valid_o    (pop_try_valid_o),
        .pop_try_i          (pop_try_i),
        .pop_try_req_o      (pop_try_req_o),
        .pop_try_ptr_o      (pop_try_ptr_o),
        .pop_commit_i       (pop_commit_i),
        .pop_commit_ptr_i   (pop_commit_ptr_i),
        .pop_rback_i        (pop_rback_i),
        .pop_rback_ptr_i    (pop_rback_ptr_i),
        .pop_rback_deps_i   (pop_rback_deps_i),
        .miss_ready_i       (miss_ready_i),
        .refill_i           (refill_i),
        .refill_nline_i     (refill_nline_i),
        .cfg_single_entry_i (cfg_single_entry_i),
        .empty_o            (empty_o),
        .full_o             (full_o)
    );

    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run("Timeout: the tests did not finish within the cycle limit");
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at %0t", $time);
    endtask

    task automatic check_req(input string name, input rtab_req_t got, input rtab_req_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: expected %h, got %h", $time, name, exp, got);
            abort_run("Request mismatch");
        end
    endtask

    task automatic check_ptr(input string name, input rtab_ptr_t got, input rtab_ptr_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: expected %h, got %h", $time, name, exp, got);
            abort_run("Pointer mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: expected %b, got %b", $time, name, exp, got);
            abort_run("Flag mismatch");
        end
    endtask

    // Ends 1 ns after the next rising edge, where inputs change
    task automatic tick();
        @(posedge clk_i);
        #1;
    endtask

    // Offer outputs depend on registers only, so they are read at the drive point
    task automatic wait_offer();
        while (pop_try_valid_o !== 1'b1) begin
            tick();
        end
    endtask

    // Any ready head may be offered, so the model entry is found by tag and line
    function automatic int find_entry(input rtab_req_t req);
        int idx;
        idx = -1;
        for (int i = 0; i < model_q.size(); i++) begin
            if (model_q[i].req.tag == req.tag && model_q[i].req.nline == req.nline) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    task automatic alloc_req(input rtab_nline_t nline, input rtab_deps_t deps, input logic link);
        parked_t ent;
        ent.req.nline  = nline;
        ent.req.offset = rtab_offset_t'($random(seed));
        ent.req.tag    = rtab_tag_t'($random(seed));
        ent.ptr        = '0;
        // New entries land in the lowest free slot
        for (int i = N - 1; i >= 0; i--) begin
            if (!used_m[i]) begin
                ent.ptr = rtab_ptr_t'(i);
            end
        end
        used_m[ent.ptr] = 1'b1;
        model_q.push_back(ent);
        alloc_i       = !link;
        alloc_link_i  = link;
        check_i       = link;
        check_nline_i = nline;
        alloc_req_i   = ent.req;
        alloc_deps_i  = deps;
        tick();
        alloc_i      = 1'b0;
        alloc_link_i = 1'b0;
        check_i      = 1'b0;
        alloc_deps_i = '0;
    endtask

    task automatic pop_one(input bit in_order, input int hold);
        rtab_req_t got_req;
        rtab_ptr_t got_ptr;
        int        idx;
        wait_offer();
        got_req = pop_try_req_o;
        got_ptr = pop_try_ptr_o;
        idx = in_order ? 0 : find_entry(got_req);
        if (idx < 0 || idx >= model_q.size()) begin
            abort_run("The offered request is not one of the parked requests");
        end
        check_req("pop_try_req_o", got_req, model_q[idx].req);
        check_ptr("pop_try_ptr_o", got_ptr, model_q[idx].ptr);
        // Back-pressure keeps the offer steady
        repeat (hold) begin
            tick();
            check_bit("pop_try_valid_o", pop_try_valid_o, 1'b1);
            check_req("pop_try_req_o", pop_try_req_o, got_req);
            check_ptr("pop_try_ptr_o", pop_try_ptr_o, got_ptr);
        end
        pop_try_i = 1'b1;
        tick();
        pop_try_i        = 1'b0;
        pop_commit_i     = 1'b1;
        pop_commit_ptr_i = got_ptr;
        tick();
        pop_commit_i    = 1'b0;
        used_m[got_ptr] = 1'b0;
        model_q.delete(idx);
    endtask

    task automatic take_and_rollback(input rtab_deps_t deps);
        rtab_ptr_t got_ptr;
        wait_offer();
        got_ptr = pop_try_ptr_o;
        check_req("pop_try_req_o", pop_try_req_o, model_q[0].req);
        check_ptr("pop_try_ptr_o", got_ptr, model_q[0].ptr);
        pop_try_i = 1'b1;
        tick();
        pop_try_i        = 1'b0;
        pop_rback_i      = 1'b1;
        pop_rback_ptr_i  = got_ptr;
        pop_rback_deps_i = deps;
        tick();
        pop_rback_i      = 1'b0;
        pop_rback_deps_i = '0;
    endtask

    task automatic expect_idle(input int cycles);
        repeat (cycles) begin
            check_bit("pop_try_valid_o", pop_try_valid_o, 1'b0);
            tick();
        end
    endtask

    task automatic pulse_refill(input rtab_nline_t nline);
        refill_i       = 1'b1;
        refill_nline_i = nline;
        tick();
        refill_i = 1'b0;
    endtask

    task automatic check_line(input rtab_nline_t nline, input logic exp);
        check_i       = 1'b1;
        check_nline_i = nline;
        #2;
        check_bit("check_hit_o", check_hit_o, exp);
        tick();
        check_i = 1'b0;
    endtask

    task automatic test_fill_and_drain();
        check_bit("empty_o", empty_o, 1'b1);
        check_bit("full_o", full_o, 1'b0);
        check_bit("pop_try_valid_o", pop_try_valid_o, 1'b0);
        for (int i = 0; i < N; i++) begin
            check_bit("full_o", full_o, 1'b0);
            alloc_req(rtab_nline_t'(16 * (i + 1)), '0, 1'b0);
        end
        check_bit("full_o", full_o, 1'b1);
        check_bit("empty_o", empty_o, 1'b0);
        pop_one(1'b0, 0);
        check_bit("full_o", full_o, 1'b0);
        while (model_q.size() > 0) begin
            pop_one(1'b0, 0);
        end
        check_bit("empty_o", empty_o, 1'b1);
    endtask

    task automatic test_linked_list();
        alloc_req(8'h5a, '0, 1'b0);
        alloc_req(8'h5a, '0, 1'b1);
        alloc_req(8'h5a, '0, 1'b1);
        check_line(8'h5a, 1'b1);
        check_line(8'h5b, 1'b0);
        check_line(8'h10, 1'b0);
        pop_one(1'b1, 0);
        pop_one(1'b1, 4);
        pop_one(1'b1, 0);
        check_bit("empty_o", empty_o, 1'b1);
    endtask

    task automatic test_rollback();
        rtab_deps_t deps;
        deps            = '0;
        deps.mshr_ready = 1'b1;
        alloc_req(8'h33, '0, 1'b0);
        take_and_rollback('0);
        take_and_rollback(deps);
        expect_idle(5);
        miss_ready_i = 1'b1;
        tick();
        miss_ready_i = 1'b0;
        pop_one(1'b1, 0);
    endtask

    task automatic test_refill_hit();
        rtab_deps_t deps;
        deps          = '0;
        deps.mshr_hit = 1'b1;
        alloc_req(8'h40, deps, 1'b0);
        expect_idle(3);
        pulse_refill(8'h47);
        expect_idle(3);
        pulse_refill(8'h40);
        pop_one(1'b1, 0);
    endtask

    task automatic test_refill_set();
        rtab_deps_t deps;
        deps           = '0;
        deps.mshr_full = 1'b1;
        alloc_req(8'h15, deps, 1'b0);
        expect_idle(3);
        // Other set leaves the flag alone, same set on another line clears it
        pulse_refill(8'h16);
        expect_idle(3);
        pulse_refill(8'h29);
        pop_one(1'b1, 0);
    endtask

    task automatic test_single_entry();
        cfg_single_entry_i = 1'b1;
        check_bit("full_o", full_o, 1'b0);
        alloc_req(8'h77, '0, 1'b0);
        check_bit("full_o", full_o, 1'b1);
        pop_one(1'b1, 0);
        check_bit("full_o", full_o, 1'b0);
        check_bit("empty_o", empty_o, 1'b1);
        cfg_single_entry_i = 1'b0;
    endtask

    initial begin
        seed               = 32'ha5442277;
        clk_i              = 1'b0;
        rst_ni             = 1'b0;
        check_i            = 1'b0;
        check_nline_i      = '0;
        alloc_i            = 1'b0;
        alloc_link_i       = 1'b0;
        alloc_req_i        = '0;
        alloc_deps_i       = '0;
        pop_try_i          = 1'b0;
        pop_commit_i       = 1'b0;
        pop_commit_ptr_i   = '0;
        pop_rback_i        = 1'b0;
        pop_rback_ptr_i    = '0;
        pop_rback_deps_i   = '0;
        miss_ready_i       = 1'b0;
        refill_i           = 1'b0;
        refill_nline_i     = '0;
        cfg_single_entry_i = 1'b0;
        used_m             = '0;
        repeat (10) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        test_fill_and_drain();
        test_linked_list();
        test_rollback();
        test_refill_hit();
        test_refill_set();
        test_single_entry();

        if (model_q.size() == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            abort_run("Requests were left in the table");
        end
    end

endmodule

/* rtab.f */
+incdir+.
rtl/rtab_pkg.sv
rtl/rtab_rr_arbiter.sv
rtl/rtab_deps_tracker.sv
rtl/rtab_entry_store.sv
rtl/rtab_pop_ctrl.sv
rtl/rtab_top.sv
tb/rtab_tb.sv

/* Makefile */
TOOL       := verilator
TOP        := rtab_tb
FILELIST   := rtab.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
